/* lc3b_core.f */
common/lc3b_isa_pkg.sv
common/lc3b_pipe_pkg.sv
execute/lc3b_alu.sv
execute/lc3b_execute_stage.sv
source/lc3b_arch_state.sv
source/lc3b_decode_stage.sv
source/lc3b_core.sv
tests/tb_lc3b_core.sv

/* tests/tb_lc3b_core.sv */
`timescale 1ns/1ps

module tb_lc3b_core;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 4;
    localparam int n_directed   = 100;  // directed strobe and idle slots
    localparam int n_random     = 200;

    localparam logic [3:0] op_add = 4'b0001;
    localparam logic [3:0] op_and = 4'b0101;
    localparam logic [3:0] op_not = 4'b1001;
    localparam logic [3:0] op_shf = 4'b1101;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [15:0] instr;
    logic        wb_valid;
    logic [2:0]  wb_dest;
    logic [15:0] wb_data;
    logic [2:0]  cc;

    logic [15:0] m_regs [8];        // reference register file
    logic [2:0]  m_cc;
    logic        exp_v    [4];      // indexed by strobe age in cycles
    logic [2:0]  exp_dest [4];
    logic [15:0] exp_data [4];
    logic [2:0]  exp_cc   [4];

    lc3b_core lc3b_core_i
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .cc          (cc)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (expected !== actual)
        begin
            $display("CHECK FAILED at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [2:0] nzp(input logic [15:0] v);
        if (v[15])
            return 3'b100;
        if (v == 16'h0000)
            return 3'b010;
        return 3'b001;
    endfunction

    function automatic logic [15:0] enc_reg(input logic [3:0] op, input logic [2:0] dr,
                                            input logic [2:0] sr1, input logic [2:0] sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic logic [15:0] enc_imm(input logic [3:0] op, input logic [2:0] dr,
                                            input logic [2:0] sr1, input logic [4:0] imm);
        return {op, dr, sr1, 1'b1, imm};
    endfunction

    // kind {a, d} is 00 for left, 01 for logical right and 11 for arithmetic right
    function automatic logic [15:0] enc_shf(input logic [2:0] dr, input logic [2:0] sr1,
                                            input logic [1:0] kind, input logic [3:0] amt);
        return {op_shf, dr, sr1, kind, amt};
    endfunction

    function automatic logic [15:0] enc_not(input logic [2:0] dr, input logic [2:0] sr1);
        return {op_not, dr, sr1, 6'h3f};
    endfunction

    task automatic model_exec(input logic [15:0] ins, output logic ok,
                              output logic [2:0] dest, output logic [15:0] data);
        logic [15:0] a;
        logic [15:0] b;
        logic [3:0]  amt;
        a    = m_regs[ins[8:6]];
        b    = ins[5] ? {{11{ins[4]}}, ins[4:0]} : m_regs[ins[2:0]];
        amt  = ins[3:0];
        ok   = 1'b1;
        dest = ins[11:9];
        data = 16'h0000;
        case (ins[15:12])
            op_add:
                data = a + b;
            op_and:
                data = a & b;
            op_not:
                data = ~a;
            op_shf:
            begin
                if (!ins[4])
                    data = a << amt;
                else if (ins[5])
                    data = (a >> amt) | (a[15] ? ~(16'hffff >> amt) : 16'h0000);
                else
                    data = a >> amt;
            end
            default:
                ok = 1'b0;          // dropped opcode
        endcase
    endtask

    // drive on the rising edge and check on the falling edge
    task automatic drive_cycle(input logic v, input logic [15:0] ins);
        logic        ok;
        logic [2:0]  dest;
        logic [15:0] data;
        int          i;
        @(posedge clk);
        instr_valid <= v;
        instr       <= ins;
        model_exec(ins, ok, dest, data);
        if (v && ok)
        begin
            m_regs[dest] = data;
            m_cc         = nzp(data);
        end
        for (i = 3; i > 0; i--)
        begin
            exp_v[i]    = exp_v[i-1];
            exp_dest[i] = exp_dest[i-1];
            exp_data[i] = exp_data[i-1];
            exp_cc[i]   = exp_cc[i-1];
        end
        exp_v[0]    = v && ok;
        exp_dest[0] = dest;
        exp_data[0] = data;
        exp_cc[0]   = m_cc;
        @(negedge clk);
        check("wb_valid", exp_v[2], wb_valid);  // two-cycle result latency
        if (exp_v[2])
        begin
            check("wb_dest", exp_dest[2], wb_dest);
            check("wb_data", exp_data[2], wb_data);
        end
        check("cc", exp_cc[3], cc);
    endtask

    task automatic drain();
        repeat (3)
            drive_cycle(1'b0, 16'h0000);
    endtask

    task automatic test_reset();
        @(negedge clk);
        check("wb_valid", 1'b0, wb_valid);
        check("cc", 3'b010, cc);
        drive_cycle(1'b1, enc_not(3'd1, 3'd0));     // r0 still zero
        drain();
    endtask

    task automatic test_arith();
        drive_cycle(1'b1, enc_imm(op_add, 3'd2, 3'd1, 5'd5));
        drive_cycle(1'b1, enc_imm(op_add, 3'd3, 3'd0, 5'h10));     // -16
        drive_cycle(1'b1, enc_imm(op_and, 3'd4, 3'd1, 5'h1d));     // -3 mask
        drive_cycle(1'b1, enc_imm(op_and, 3'd5, 3'd3, 5'h0f));
        drive_cycle(1'b1, enc_reg(op_add, 3'd6, 3'd2, 3'd3));
        drive_cycle(1'b1, enc_reg(op_and, 3'd7, 3'd3, 3'd1));
        drive_cycle(1'b1, enc_reg(op_add, 3'd0, 3'd3, 3'd3));
        drive_cycle(1'b1, enc_imm(op_and, 3'd1, 3'd1, 5'd0));      // zero result
        drain();
    endtask

    task automatic test_shifts();
        logic [3:0] amts [3];
        int         k;
        amts = '{4'd0, 4'd1, 4'd15};
        drive_cycle(1'b1, enc_imm(op_and, 3'd1, 3'd1, 5'd0));
        drive_cycle(1'b1, enc_imm(op_add, 3'd1, 3'd1, 5'h13));     // r1 = fff3
        for (k = 0; k < 3; k++)
        begin
            drive_cycle(1'b1, enc_shf(3'd2, 3'd1, 2'b00, amts[k]));
            drive_cycle(1'b1, enc_shf(3'd3, 3'd1, 2'b01, amts[k]));
            drive_cycle(1'b1, enc_shf(3'd4, 3'd1, 2'b11, amts[k]));
        end
        drain();
    endtask

    task automatic test_forwarding();
        int d;
        for (d = 1; d <= 3; d++)
        begin
            drive_cycle(1'b1, enc_imm(op_add, 3'd3, 3'd3, 5'd7));
            repeat (d - 1)
                drive_cycle(1'b1, enc_imm(op_and, 3'd7, 3'd6, 5'h1f));
            drive_cycle(1'b1, enc_reg(op_add, 3'd4, 3'd3, 3'd6));  // src1 at distance d
            drive_cycle(1'b1, enc_imm(op_add, 3'd5, 3'd5, 5'h1e));
            repeat (d - 1)
                drive_cycle(1'b1, enc_imm(op_and, 3'd7, 3'd6, 5'h1f));
            drive_cycle(1'b1, enc_reg(op_add, 3'd2, 3'd6, 3'd5));  // src2 at distance d
        end
        drive_cycle(1'b1, enc_imm(op_add, 3'd1, 3'd0, 5'd9));
        drive_cycle(1'b1, enc_reg(op_add, 3'd2, 3'd1, 3'd1));      // both sources
        drive_cycle(1'b1, enc_not(3'd3, 3'd2));
        drain();
    endtask

    task automatic test_dropped();
        int op;
        for (op = 0; op < 16; op++)
        begin
            if (op != 1 && op != 5 && op != 9 && op != 13)
            begin
                drive_cycle(1'b1, {op[3:0], 12'ha5c});
                drive_cycle(1'b0, enc_imm(op_add, 3'd0, 3'd0, 5'd1));  // ignored without a strobe
            end
        end
        for (op = 0; op < 8; op++)
            drive_cycle(1'b1, enc_imm(op_add, op[2:0], op[2:0], 5'd0));   // read back
        drain();
    endtask

    task automatic test_random();
        logic [3:0]  kept_ops [4];
        logic [31:0] r;
        logic [15:0] ins;
        int          n;
        kept_ops = '{op_add, op_and, op_not, op_shf};
        for (n = 0; n < n_random; n++)
        begin
            repeat ($urandom_range(2))
                drive_cycle(1'b0, 16'($urandom));
            r   = $urandom;
            ins = {kept_ops[$urandom_range(3)], r[11:0]};
            if (ins[15:12] == op_not)
                ins[5:0] = 6'h3f;
            else if (ins[15:12] != op_shf && !ins[5])
                ins[4:3] = 2'b00;
            drive_cycle(1'b1, ins);
        end
        drain();
    endtask

    initial
    begin
        #((n_directed + n_random + reset_cycles) * 4 * clk_period);
        $display("run timed out before all tests completed");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        int i;
        void'($urandom(32'hd4b6d753));
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 16'h0000;
        m_cc        = 3'b010;
        for (i = 0; i < 8; i++)
            m_regs[i] = 16'h0000;
        for (i = 0; i < 4; i++)
        begin
            exp_v[i]    = 1'b0;
            exp_dest[i] = 3'd0;
            exp_data[i] = 16'h0000;
            exp_cc[i]   = 3'b010;
        end
        repeat (reset_cycles)
            @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_arith();
        test_shifts();
        test_forwarding();
        test_dropped();
        test_random();
        $display("Verification passed");
        $finish;
    end

endmodule : tb_lc3b_core

/* source/lc3b_core.sv */
`timescale 1ns/1ps

module lc3b_core
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  lc3b_word   instr,
    output logic       wb_valid,
    output lc3b_reg    wb_dest,
    output lc3b_word   wb_data,
    output logic [2:0] cc
);

    lc3b_reg   rd_idx_a;
    lc3b_reg   rd_idx_b;
    lc3b_word  rd_data_a;
    lc3b_word  rd_data_b;

    logic      de_valid;
    lc3b_aluop de_aluop;
    lc3b_reg   de_dest;
    lc3b_reg   de_src1;
    lc3b_reg   de_src2;
    logic      de_use_src2;
    lc3b_word  de_src1_data;
    lc3b_word  de_opnd_b;

    logic      ex_valid;
    lc3b_reg   ex_dest;
    lc3b_word  ex_result;

    lc3b_decode_stage decode_stage_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rd_idx_a     (rd_idx_a),
        .rd_idx_b     (rd_idx_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .de_valid     (de_valid),
        .de_aluop     (de_aluop),
        .de_dest      (de_dest),
        .de_src1      (de_src1),
        .de_src2      (de_src2),
        .de_use_src2  (de_use_src2),
        .de_src1_data (de_src1_data),
        .de_opnd_b    (de_opnd_b)
    );

    lc3b_execute_stage execute_stage_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .de_valid     (de_valid),
        .de_aluop     (de_aluop),
        .de_dest      (de_dest),
        .de_src1      (de_src1),
        .de_src2      (de_src2),
        .de_use_src2  (de_use_src2),
        .de_src1_data (de_src1_data),
        .de_opnd_b    (de_opnd_b),
        .ex_valid     (ex_valid),
        .ex_dest      (ex_dest),
        .ex_result    (ex_result)
    );

    // ex registers double as the regfile write port
    lc3b_arch_state arch_state_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (ex_valid),
        .wr_idx    (ex_dest),
        .wr_data   (ex_result),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .cc        (cc)
    );

    assign wb_valid = ex_valid;
    assign wb_dest  = ex_dest;
    assign wb_data  = ex_result;

endmodule : lc3b_core

/* source/lc3b_decode_stage.sv */
`timescale 1ns/1ps

module lc3b_decode_stage
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  lc3b_word  instr,
    output lc3b_reg   rd_idx_a,
    output lc3b_reg   rd_idx_b,
    input  lc3b_word  rd_data_a,
    input  lc3b_word  rd_data_b,
    output logic      de_valid,
    output lc3b_aluop de_aluop,
    output lc3b_reg   de_dest,
    output lc3b_reg   de_src1,
    output lc3b_reg   de_src2,
    output logic      de_use_src2,
    output lc3b_word  de_src1_data,
    output lc3b_word  de_opnd_b
);

    lc3b_instr_u ir;
    logic        dec_ok;            // opcode is one we execute
    lc3b_aluop   dec_aluop;
    logic        dec_use_src2;
    lc3b_word    dec_imm;

    assign ir       = instr;
    assign rd_idx_a = ir.r.src1;
    assign rd_idx_b = ir.r.src2;

    always_comb
    begin
        dec_ok       = 1'b1;
        dec_aluop    = alu_add;
        dec_use_src2 = 1'b0;
        dec_imm      = {{11{ir.i.imm5[4]}}, ir.i.imm5};     // sext5
        case (ir.r.opcode)
            op_add:
            begin
                dec_aluop    = alu_add;
                dec_use_src2 = ~ir.r.mode;
            end
            op_and:
            begin
                dec_aluop    = alu_and;
                dec_use_src2 = ~ir.r.mode;
            end
            op_not:
            begin
                dec_aluop = alu_not;
                dec_imm   = 16'hffff;       // all-ones operand
            end
            op_shf:
            begin
                dec_imm = {12'h000, ir.s.amount};   // zext4
                if (!ir.s.d)
                    dec_aluop = alu_lshf;
                else if (ir.s.a)
                    dec_aluop = alu_rshfa;
                else
                    dec_aluop = alu_rshfl;
            end
            default:
                dec_ok = 1'b0;          // accepted but never written back
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            de_valid <= 1'b0;
        else
            de_valid <= instr_valid && dec_ok;
    end

    always_ff @(posedge clk)
    begin
        de_aluop     <= dec_aluop;
        de_dest      <= ir.r.dest;
        de_src1      <= ir.r.src1;
        de_src2      <= ir.r.src2;
        de_use_src2  <= dec_use_src2;
        de_src1_data <= rd_data_a;
        de_opnd_b    <= dec_use_src2 ? rd_data_b : dec_imm;
    end

endmodule : lc3b_decode_stage

/* source/lc3b_arch_state.sv */
`timescale 1ns/1ps

module lc3b_arch_state
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  lc3b_reg    wr_idx,
    input  lc3b_word   wr_data,
    input  lc3b_reg    rd_idx_a,
    input  lc3b_reg    rd_idx_b,
    output lc3b_word   rd_data_a,
    output lc3b_word   rd_data_b,
    output logic [2:0] cc
);

    lc3b_word   regs [8];
    logic [2:0] cc_next;

    // nzp from the value being written
    always_comb
    begin
        if (wr_data[15])
            cc_next = 3'b100;
        else if (wr_data == 16'h0000)
            cc_next = 3'b010;
        else
            cc_next = 3'b001;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
            cc <= cc_reset;
        end
        else if (wr_en)
        begin
            regs[wr_idx] <= wr_data;
            cc           <= cc_next;
        end
    end

    // write-through so a read in the writing cycle sees the new value
    assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
    assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule : lc3b_arch_state

/* execute/lc3b_execute_stage.sv */
`timescale 1ns/1ps

module lc3b_execute_stage
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      de_valid,
    input  lc3b_aluop de_aluop,
    input  lc3b_reg   de_dest,
    input  lc3b_reg   de_src1,
    input  lc3b_reg   de_src2,
    input  logic      de_use_src2,
    input  lc3b_word  de_src1_data,
    input  lc3b_word  de_opnd_b,
    output logic      ex_valid,
    output lc3b_reg   ex_dest,
    output lc3b_word  ex_result
);

    logic     fwd_a;
    logic     fwd_b;
    lc3b_word opnd_a;
    lc3b_word opnd_b;
    lc3b_word alu_f;

    // previous instruction still sits in the ex registers
    assign fwd_a  = ex_valid && (ex_dest == de_src1);
    assign fwd_b  = ex_valid && de_use_src2 && (ex_dest == de_src2);   // imm never forwarded
    assign opnd_a = fwd_a ? ex_result : de_src1_data;
    assign opnd_b = fwd_b ? ex_result : de_opnd_b;

    lc3b_alu alu_i
    (
        .aluop (de_aluop),
        .a     (opnd_a),
        .b     (opnd_b),
        .f     (alu_f)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= de_valid;
    end

    always_ff @(posedge clk)
    begin
        ex_dest   <= de_dest;
        ex_result <= alu_f;
    end

endmodule : lc3b_execute_stage

/* execute/lc3b_alu.sv */
`timescale 1ns/1ps

module lc3b_alu
    import lc3b_isa_pkg::*;
    import lc3b_pipe_pkg::*;
(
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    logic [3:0] shamt;

    assign shamt = b[3:0];      // shift amount in low bits

    always_comb
    begin
        case (aluop)
            alu_add:
                f = a + b;
            alu_and:
                f = a & b;
            alu_not:
                f = ~a;
            alu_lshf:
                f = a << shamt;
            alu_rshfl:
                f = a >> shamt;
            alu_rshfa:
                f = $signed(a) >>> shamt;   // sign fill
            default:
                f = '0;
        endcase
    end

endmodule : lc3b_alu

/* common/lc3b_pipe_pkg.sv */
package lc3b_pipe_pkg;

    typedef logic [2:0] lc3b_aluop;

    localparam lc3b_aluop alu_add   = 3'd0;
    localparam lc3b_aluop alu_and   = 3'd1;
    localparam lc3b_aluop alu_not   = 3'd2;
    localparam lc3b_aluop alu_lshf  = 3'd3;
    localparam lc3b_aluop alu_rshfl = 3'd4;
    localparam lc3b_aluop alu_rshfa = 3'd5;

    // nzp after reset has only the zero flag set
    localparam logic [2:0] cc_reset = 3'b010;

endpackage : lc3b_pipe_pkg

/* common/lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [3:0]  lc3b_opcode;

    localparam lc3b_opcode op_add = 4'b0001;
    localparam lc3b_opcode op_and = 4'b0101;
    localparam lc3b_opcode op_not = 4'b1001;
    localparam lc3b_opcode op_shf = 4'b1101;

    // three field layouts over the same instruction bits
    typedef union packed
    {
        struct packed
        {
            lc3b_opcode opcode;
            lc3b_reg    dest;
            lc3b_reg    src1;
            logic       mode;       // low for register form
            logic [1:0] zero;
            lc3b_reg    src2;
        } r;
        struct packed
        {
            lc3b_opcode opcode;
            lc3b_reg    dest;
            lc3b_reg    src1;
            logic       mode;       // high for immediate form
            logic [4:0] imm5;       // two's complement
        } i;
        struct packed
        {
            lc3b_opcode opcode;
            lc3b_reg    dest;
            lc3b_reg    src1;
            logic       a;          // arithmetic right shift
            logic       d;          // 0 left, 1 right
            logic [3:0] amount;
        } s;
    } lc3b_instr_u;

endpackage : lc3b_isa_pkg
